/* mem_to_axi3_adapter.f */
hdl/mem_axi3_pkg.sv
hdl/sync_fifo.sv
hdl/burst_coalescer.sv
hdl/axi3_write_channel.sv
hdl/axi3_read_channel.sv
hdl/mem_to_axi3_adapter.sv
testbench/axi3_mem_model.sv
testbench/tb_mem_to_axi3_adapter.sv

/* Bender.yml */
package:
  name: mem_to_axi3_adapter

sources:
  - files:
      - hdl/mem_axi3_pkg.sv
      - hdl/sync_fifo.sv
      - hdl/burst_coalescer.sv
      - hdl/axi3_write_channel.sv
      - hdl/axi3_read_channel.sv
      - hdl/mem_to_axi3_adapter.sv
  - target: test
    files:
      - testbench/axi3_mem_model.sv
      - testbench/tb_mem_to_axi3_adapter.sv

/* testbench/tb_mem_to_axi3_adapter.sv */
/*
 * Testbench for the memory to AXI3 bridge
 * Directed and random traffic checked against a burst reference model.
 */
`timescale 1ns/1ns

module tb_mem_to_axi3_adapter;
    import mem_axi3_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;

    typedef struct packed {
        int         cycle;
        word_addr_t addr;
    } acc_t;
    typedef acc_t     acc_q_t[$];
    typedef axi3_ax_t ax_q_t[$];

    logic        clk = 1'b0;
    logic        srst;
    logic        mem_wr_req;
    mem_wr_req_t mem_wr;
    logic        mem_wr_rdy;
    logic        mem_wr_ack;
    logic        mem_rd_req;
    word_addr_t  mem_rd_addr;
    logic        mem_rd_rdy;
    logic        mem_rd_ack;
    word_t       mem_rd_data;
    logic        awvalid;
    logic        awready;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic        arvalid;
    logic        arready;
    logic        rvalid;
    logic        rready;
    axi3_ax_t    aw;
    axi3_ax_t    ar;
    axi3_w_t     w;
    axi3_r_t     r;

    integer      seed = 32'h44ee3549;
    int          cycle_cnt;
    int          errors;
    int          tests;
    int          wr_ack_cnt;
    acc_q_t      wr_acc;
    acc_q_t      rd_acc;
    word_t       exp_rd_q[$];
    word_t       rd_data_q[$];
    word_t       shadow [word_addr_t];

    always #4 clk = ~clk;

    mem_to_axi3_adapter uut (.*);

    axi3_mem_model mem_model (.*);

    function automatic axi_addr_t byte_addr(input word_addr_t a);
        return BASE_ADDR + axi_addr_t'(a) * DATA_BYTES;
    endfunction

    function automatic word_t expected_word(input word_addr_t a);
        axi_addr_t b;
        b = byte_addr(a);
        return shadow.exists(a) ? shadow[a] : {b, ~b};
    endfunction

    // Burst rule applied to the accepted requests
    function automatic ax_q_t expected_bursts(input acc_q_t acc);
        ax_q_t      q;
        word_addr_t start;
        int         n;
        for (int i = 0; i < acc.size(); i++) begin
            if (i == 0 || acc[i].cycle != acc[i-1].cycle + 1 ||
                acc[i].addr != word_addr_t'(acc[i-1].addr + 1) || n == MAX_BURST_LEN) begin
                if (i > 0) begin
                    q.push_back('{addr: byte_addr(start), len: burst_len_t'(n - 1)});
                end
                start = acc[i].addr;
                n     = 1;
            end else begin
                n++;
            end
        end
        if (acc.size() > 0) begin
            q.push_back('{addr: byte_addr(start), len: burst_len_t'(n - 1)});
        end
        return q;
    endfunction

    // Accepted requests and acks sampled at the ports
    always @(posedge clk) begin
        if (!srst) begin
            if (mem_wr_req && mem_wr_rdy) begin
                wr_acc.push_back('{cycle: cycle_cnt, addr: mem_wr.addr});
                shadow[mem_wr.addr] = mem_wr.data;
            end
            if (mem_rd_req && mem_rd_rdy) begin
                rd_acc.push_back('{cycle: cycle_cnt, addr: mem_rd_addr});
                exp_rd_q.push_back(expected_word(mem_rd_addr));
            end
            if (mem_wr_ack) begin
                wr_ack_cnt++;
            end
            if (mem_rd_ack) begin
                rd_data_q.push_back(mem_rd_data);
            end
        end
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_burst(input string name, input axi3_ax_t got, input axi3_ax_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_bursts(input string name, input ax_q_t got, input ax_q_t exp);
        if (got.size() != exp.size()) begin
            $display("%s: %0d bursts seen but %0d expected", name, got.size(), exp.size());
            errors++;
        end
        for (int i = 0; i < got.size() && i < exp.size(); i++) begin
            check_burst(name, got[i], exp[i]);
        end
    endtask

    // ----------------------------------------
    // Stimulus tasks start and end on a falling edge
    // ----------------------------------------
    task automatic write_req(input word_addr_t a, input word_t d);
        mem_wr_req = 1'b1;
        mem_wr     = '{addr: a, data: d};
        while (!mem_wr_rdy) begin
            @(negedge clk);
        end
        @(negedge clk);
        mem_wr_req = 1'b0;
    endtask

    task automatic read_req(input word_addr_t a);
        mem_rd_req  = 1'b1;
        mem_rd_addr = a;
        while (!mem_rd_rdy) begin
            @(negedge clk);
        end
        @(negedge clk);
        mem_rd_req = 1'b0;
    endtask

    task automatic wait_idle();
        repeat (2) @(negedge clk);
        while (wr_ack_cnt != wr_acc.size() || rd_data_q.size() != rd_acc.size()) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    // Common checks and the report line of each test
    task automatic finish_test(input string name, input int errs_before);
        compare_bursts("aw", mem_model.aw_log, expected_bursts(wr_acc));
        compare_bursts("ar", mem_model.ar_log, expected_bursts(rd_acc));
        if (wr_ack_cnt != wr_acc.size()) begin
            $display("%0d write acks seen for %0d accepted writes", wr_ack_cnt, wr_acc.size());
            errors++;
        end
        if (rd_data_q.size() != rd_acc.size()) begin
            $display("%0d read acks seen for %0d accepted reads", rd_data_q.size(),
                     rd_acc.size());
            errors++;
        end
        for (int i = 0; i < rd_data_q.size() && i < exp_rd_q.size(); i++) begin
            check_word("mem_rd_data", rd_data_q[i], exp_rd_q[i]);
        end
        foreach (wr_acc[i]) begin
            check_word("mem_model.mem", mem_model.read_word(byte_addr(wr_acc[i].addr)),
                       shadow[wr_acc[i].addr]);
        end
        if (mem_model.beat_errs != 0) begin
            $display("W beats arrived out of place or with a wrong last flag");
            errors++;
        end
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errs_before);
        wr_acc.delete();
        rd_acc.delete();
        exp_rd_q.delete();
        rd_data_q.delete();
        mem_model.aw_log.delete();
        mem_model.ar_log.delete();
        mem_model.beat_errs = 0;
        wr_ack_cnt = 0;
    endtask

    initial begin
        int         e;
        word_addr_t wa;
        word_addr_t ra;
        srst        = 1'b1;
        mem_wr_req  = 1'b0;
        mem_wr      = '0;
        mem_rd_req  = 1'b0;
        mem_rd_addr = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        srst = 1'b0;

        // Outputs straight out of reset
        e = errors;
        check_flag("awvalid", awvalid, 1'b0);
        check_flag("wvalid", wvalid, 1'b0);
        check_flag("arvalid", arvalid, 1'b0);
        check_flag("mem_rd_ack", mem_rd_ack, 1'b0);
        check_flag("mem_wr_rdy", mem_wr_rdy, 1'b1);
        check_flag("mem_rd_rdy", mem_rd_rdy, 1'b1);
        check_flag("bready", bready, 1'b1);
        check_flag("rready", rready, 1'b1);
        finish_test("reset state", e);
        @(negedge clk);

        // Single burst of five
        e = errors;
        for (int i = 0; i < 5; i++) begin
            write_req(16'h0010 + i, {$random(seed), $random(seed)});
        end
        wait_idle();
        if (wr_ack_cnt != 5) begin
            $display("%0d write acks seen where 5 were expected", wr_ack_cnt);
            errors++;
        end
        compare_bursts("aw", mem_model.aw_log, '{'{addr: BASE_ADDR + 32'h80, len: 4'd4}});
        finish_test("five consecutive writes", e);

        // Split at the burst limit
        e = errors;
        for (int i = 0; i < 20; i++) begin
            write_req(16'h0040 + i, {$random(seed), $random(seed)});
        end
        wait_idle();
        compare_bursts("aw", mem_model.aw_log,
                       '{'{addr: BASE_ADDR + 32'h200, len: 4'd15},
                         '{addr: BASE_ADDR + 32'h280, len: 4'd3}});
        finish_test("twenty consecutive writes", e);

        // Address jumps and idle cycles
        e = errors;
        write_req(16'h0080, {$random(seed), $random(seed)});
        write_req(16'h0081, {$random(seed), $random(seed)});
        write_req(16'h0085, {$random(seed), $random(seed)});
        @(negedge clk);
        write_req(16'h0086, {$random(seed), $random(seed)});
        write_req(16'h0087, {$random(seed), $random(seed)});
        write_req(16'h0030, {$random(seed), $random(seed)});
        repeat (2) @(negedge clk);
        write_req(16'h0031, {$random(seed), $random(seed)});
        wait_idle();
        finish_test("gaps and jumps", e);

        // Read back earlier writes
        e = errors;
        for (int i = 0; i < 5; i++) begin
            read_req(16'h0010 + i);
        end
        for (int i = 0; i < 4; i++) begin
            read_req(16'h0040 + i);
        end
        read_req(16'h0085);
        @(negedge clk);
        read_req(16'h0030);
        wait_idle();
        finish_test("read back", e);

        // Random mix with writes and reads in separate regions
        e = errors;
        mem_model.rand_ready = 1'b1;
        wa = 16'h1000;
        ra = 16'h0000;
        for (int i = 0; i < 200; i++) begin
            wa = (($random(seed) & 3) != 0) ? wa + 1'b1 : 16'h1000 + ($random(seed) & 8'hff);
            ra = (($random(seed) & 3) != 0) ? ra + 1'b1 : word_addr_t'($random(seed) & 8'hff);
            mem_wr_req  = $random(seed) & 1;
            mem_wr      = '{addr: wa, data: {$random(seed), $random(seed)}};
            mem_rd_req  = $random(seed) & 1;
            mem_rd_addr = ra;
            @(negedge clk);
        end
        mem_wr_req = 1'b0;
        mem_rd_req = 1'b0;
        wait_idle();
        finish_test("random traffic", e);

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_mem_to_axi3_adapter

/* testbench/axi3_mem_model.sv */
/*
 * AXI3 memory responder for the bridge testbench
 * Random ready, byte-addressed storage and a log of AW and AR bursts.
 */
`timescale 1ns/1ns

module axi3_mem_model (
    input  logic                   clk,
    input  logic                   srst,
    input  logic                   awvalid,
    input  mem_axi3_pkg::axi3_ax_t aw,
    output logic                   awready,
    input  logic                   wvalid,
    input  mem_axi3_pkg::axi3_w_t  w,
    output logic                   wready,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic                   arvalid,
    input  mem_axi3_pkg::axi3_ax_t ar,
    output logic                   arready,
    output logic                   rvalid,
    output mem_axi3_pkg::axi3_r_t  r,
    input  logic                   rready
);
    import mem_axi3_pkg::*;

    integer     seed = 32'h44ee3549;
    bit         rand_ready;
    int         beat_errs;
    int         b_pend;
    axi3_ax_t   aw_log[$];
    axi3_ax_t   ar_log[$];
    axi3_ax_t   w_q[$];
    axi3_ax_t   r_q[$];
    burst_len_t w_beat;
    burst_len_t r_beat;
    word_t      mem [axi_addr_t];

    // Unwritten locations return a pattern of their own address
    function automatic word_t read_word(input axi_addr_t a);
        return mem.exists(a) ? mem[a] : {a, ~a};
    endfunction

    function automatic axi_addr_t beat_addr(input axi3_ax_t ax, input burst_len_t beat);
        return ax.addr + axi_addr_t'(beat) * DATA_BYTES;
    endfunction

    initial begin
        awready = 1'b0;
        wready  = 1'b0;
        arready = 1'b0;
        bvalid  = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
    end

    // ----------------------------------------
    // Transfers seen on the rising edge
    // ----------------------------------------
    always @(posedge clk) begin
        if (srst) begin
            w_beat = '0;
            r_beat = '0;
            b_pend = 0;
            w_q.delete();
            r_q.delete();
        end else begin
            if (awvalid && awready) begin
                aw_log.push_back(aw);
                w_q.push_back(aw);
            end
            if (wvalid && wready) begin
                if (w_q.size() == 0) begin
                    beat_errs++;
                end else begin
                    mem[beat_addr(w_q[0], w_beat)] = w.data;
                    if (w.last != (w_beat == w_q[0].len)) begin
                        beat_errs++;
                    end
                    if (w_beat == w_q[0].len) begin
                        void'(w_q.pop_front());
                        w_beat = '0;
                        b_pend++;
                    end else begin
                        w_beat++;
                    end
                end
            end
            if (bvalid && bready) begin
                b_pend--;
            end
            if (arvalid && arready) begin
                ar_log.push_back(ar);
                r_q.push_back(ar);
            end
            if (rvalid && rready) begin
                if (r_beat == r_q[0].len) begin
                    void'(r_q.pop_front());
                    r_beat = '0;
                end else begin
                    r_beat++;
                end
            end
        end
    end

    // Outputs change on the falling edge
    always @(negedge clk) begin
        awready = rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
        wready  = rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
        arready = rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
        bvalid  = (b_pend > 0);
        rvalid  = (r_q.size() > 0);
        if (r_q.size() > 0) begin
            r = '{data: read_word(beat_addr(r_q[0], r_beat)), last: (r_beat == r_q[0].len)};
        end
    end

endmodule : axi3_mem_model

/* hdl/mem_to_axi3_adapter.sv */
/*
 * Memory request port to AXI3 controller bridge
 * Joins the write and read paths, B channel always ready.
 */
`timescale 1ns/1ns

module mem_to_axi3_adapter (
    input  logic                      clk,
    input  logic                      srst,

    // Memory write port
    input  logic                      mem_wr_req,
    input  mem_axi3_pkg::mem_wr_req_t mem_wr,
    output logic                      mem_wr_rdy,
    output logic                      mem_wr_ack,

    // Memory read port
    input  logic                      mem_rd_req,
    input  mem_axi3_pkg::word_addr_t  mem_rd_addr,
    output logic                      mem_rd_rdy,
    output logic                      mem_rd_ack,
    output mem_axi3_pkg::word_t       mem_rd_data,

    // AXI3 controller
    output logic                      awvalid,
    output mem_axi3_pkg::axi3_ax_t    aw,
    input  logic                      awready,
    output logic                      wvalid,
    output mem_axi3_pkg::axi3_w_t     w,
    input  logic                      wready,
    input  logic                      bvalid,
    output logic                      bready,
    output logic                      arvalid,
    output mem_axi3_pkg::axi3_ax_t    ar,
    input  logic                      arready,
    input  logic                      rvalid,
    input  mem_axi3_pkg::axi3_r_t     r,
    output logic                      rready
);

    axi3_write_channel i_axi3_write_channel (
        .clk        ( clk ),
        .srst       ( srst ),
        .mem_wr_req ( mem_wr_req ),
        .mem_wr     ( mem_wr ),
        .mem_wr_rdy ( mem_wr_rdy ),
        .mem_wr_ack ( mem_wr_ack ),
        .awvalid    ( awvalid ),
        .aw         ( aw ),
        .awready    ( awready ),
        .wvalid     ( wvalid ),
        .w          ( w ),
        .wready     ( wready )
    );

    // Responses are not checked
    assign bready = 1'b1;

    axi3_read_channel i_axi3_read_channel (
        .clk         ( clk ),
        .srst        ( srst ),
        .mem_rd_req  ( mem_rd_req ),
        .mem_rd_addr ( mem_rd_addr ),
        .mem_rd_rdy  ( mem_rd_rdy ),
        .mem_rd_ack  ( mem_rd_ack ),
        .mem_rd_data ( mem_rd_data ),
        .arvalid     ( arvalid ),
        .ar          ( ar ),
        .arready     ( arready ),
        .rvalid      ( rvalid ),
        .r           ( r ),
        .rready      ( rready )
    );

endmodule : mem_to_axi3_adapter

/* hdl/axi3_read_channel.sv */
/*
 * AXI3 read path
 * Coalesces reads into bursts, issues AR per burst and returns
 * each R beat to the memory side one cycle later.
 */
`timescale 1ns/1ns

module axi3_read_channel (
    input  logic                     clk,
    input  logic                     srst,

    input  logic                     mem_rd_req,
    input  mem_axi3_pkg::word_addr_t mem_rd_addr,
    output logic                     mem_rd_rdy,
    output logic                     mem_rd_ack,
    output mem_axi3_pkg::word_t      mem_rd_data,

    output logic                     arvalid,
    output mem_axi3_pkg::axi3_ax_t   ar,
    input  logic                     arready,

    input  logic                     rvalid,
    input  mem_axi3_pkg::axi3_r_t    r,
    output logic                     rready
);
    import mem_axi3_pkg::*;

    localparam int LVL_WID = $clog2(CTXT_FIFO_DEPTH + 1);

    logic               rd_accept;
    logic               rd_open;
    logic               ctxt_push;
    burst_ctxt_t        ctxt_in;
    burst_ctxt_t        ctxt_head;
    logic               ar_fire;
    logic [LVL_WID-1:0] ctxt_level;

    assign rd_accept = mem_rd_req && mem_rd_rdy;

    // Keep a slot for the open burst so its close never meets a full FIFO
    assign mem_rd_rdy = (ctxt_level + LVL_WID'(rd_open)) < LVL_WID'(CTXT_FIFO_DEPTH);

    always_ff @(posedge clk) begin
        if (srst) begin
            rd_open    <= 1'b0;
            ctxt_level <= '0;
        end else begin
            rd_open <= rd_accept;
            case ({ctxt_push, ar_fire})
                2'b10:   ctxt_level <= ctxt_level + 1'b1;
                2'b01:   ctxt_level <= ctxt_level - 1'b1;
                default: ctxt_level <= ctxt_level;
            endcase
        end
    end

    burst_coalescer i_burst_coalescer (
        .clk       ( clk ),
        .srst      ( srst ),
        .accept    ( rd_accept ),
        .addr      ( mem_rd_addr ),
        .ctxt_push ( ctxt_push ),
        .ctxt      ( ctxt_in )
    );

    sync_fifo #(
        .T     ( burst_ctxt_t ),
        .DEPTH ( CTXT_FIFO_DEPTH )
    ) i_sync_fifo__ctxt (
        .clk     ( clk ),
        .srst    ( srst ),
        .wr      ( ctxt_push ),
        .wr_data ( ctxt_in ),
        .wr_rdy  ( ),
        .rd      ( ar_fire ),
        .rd_vld  ( arvalid ),
        .rd_data ( ctxt_head )
    );

    // Head context goes out as the AR transfer
    assign ar      = '{addr: word_to_axi_addr(ctxt_head.addr), len: ctxt_head.len};
    assign ar_fire = arvalid && arready;

    // ----------------------------------------
    // Read data return
    // ----------------------------------------
    assign rready = 1'b1;

    always_ff @(posedge clk) begin
        if (srst) begin
            mem_rd_ack <= 1'b0;
        end else begin
            mem_rd_ack <= rvalid && rready;
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid && rready) begin
            mem_rd_data <= r.data;
        end
    end

endmodule : axi3_read_channel

/* hdl/axi3_write_channel.sv */
/*
 * AXI3 write path
 * Buffers write words, coalesces them into bursts, issues AW per
 * burst and sequences the W beats with last on beat len.
 */
`timescale 1ns/1ns

module axi3_write_channel (
    input  logic                      clk,
    input  logic                      srst,

    input  logic                      mem_wr_req,
    input  mem_axi3_pkg::mem_wr_req_t mem_wr,
    output logic                      mem_wr_rdy,
    output logic                      mem_wr_ack,

    output logic                      awvalid,
    output mem_axi3_pkg::axi3_ax_t    aw,
    input  logic                      awready,

    output logic                      wvalid,
    output mem_axi3_pkg::axi3_w_t     w,
    input  logic                      wready
);
    import mem_axi3_pkg::*;

    logic        wr_accept;
    logic        data_vld;
    word_t       w_data;
    logic        w_last;
    logic        ctxt_push;
    burst_ctxt_t ctxt_in;
    logic        ctxt_vld;
    burst_ctxt_t ctxt_head;
    logic        aw_fire;
    logic        w_fire;
    logic        w_sop;
    logic        aw_pend;
    burst_len_t  beat_cnt;
    burst_len_t  aw_len;

    assign wr_accept = mem_wr_req && mem_wr_rdy;

    // ----------------------------------------
    // Data and burst contexts
    // ----------------------------------------
    sync_fifo #(
        .T     ( word_t ),
        .DEPTH ( DATA_FIFO_DEPTH )
    ) i_sync_fifo__data (
        .clk     ( clk ),
        .srst    ( srst ),
        .wr      ( wr_accept ),
        .wr_data ( mem_wr.data ),
        .wr_rdy  ( mem_wr_rdy ),
        .rd      ( w_fire ),
        .rd_vld  ( data_vld ),
        .rd_data ( w_data )
    );

    burst_coalescer i_burst_coalescer (
        .clk       ( clk ),
        .srst      ( srst ),
        .accept    ( wr_accept ),
        .addr      ( mem_wr.addr ),
        .ctxt_push ( ctxt_push ),
        .ctxt      ( ctxt_in )
    );

    // Every queued context still has its words in the data FIFO,
    // so this one cannot fill before the data FIFO does
    sync_fifo #(
        .T     ( burst_ctxt_t ),
        .DEPTH ( CTXT_FIFO_DEPTH )
    ) i_sync_fifo__ctxt (
        .clk     ( clk ),
        .srst    ( srst ),
        .wr      ( ctxt_push ),
        .wr_data ( ctxt_in ),
        .wr_rdy  ( ),
        .rd      ( aw_fire ),
        .rd_vld  ( ctxt_vld ),
        .rd_data ( ctxt_head )
    );

    // ----------------------------------------
    // AW issue
    // ----------------------------------------
    assign awvalid = w_sop && ctxt_vld && !aw_pend;
    assign aw      = '{addr: word_to_axi_addr(ctxt_head.addr), len: ctxt_head.len};
    assign aw_fire = awvalid && awready;

    // Length of the burst the W side works on
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            aw_len <= ctxt_head.len;
        end
    end

    // ----------------------------------------
    // W beats
    // ----------------------------------------
    // First beat waits until its AW has gone out
    assign wvalid = data_vld && (!w_sop || aw_pend);
    assign w_last = (beat_cnt == aw_len);
    assign w      = '{data: w_data, last: w_last};
    assign w_fire = wvalid && wready;

    always_ff @(posedge clk) begin
        if (srst) begin
            w_sop    <= 1'b1;
            aw_pend  <= 1'b0;
            beat_cnt <= '0;
        end else begin
            if (aw_fire) begin
                aw_pend <= 1'b1;
            end else if (w_fire && w_sop) begin
                aw_pend <= 1'b0;
            end
            if (w_fire) begin
                w_sop    <= w_last;
                beat_cnt <= w_last ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    // One ack per word, on its W transfer
    assign mem_wr_ack = w_fire;

endmodule : axi3_write_channel

/* hdl/burst_coalescer.sv */
/*
 * Burst coalescer
 * Merges accepted requests with consecutive word addresses into
 * INCR burst contexts of up to MAX_BURST_LEN beats.
 */
`timescale 1ns/1ns

module burst_coalescer (
    input  logic                      clk,
    input  logic                      srst,

    input  logic                      accept,
    input  mem_axi3_pkg::word_addr_t  addr,

    output logic                      ctxt_push,
    output mem_axi3_pkg::burst_ctxt_t ctxt
);
    import mem_axi3_pkg::*;

    typedef enum logic [1:0] {
        ST_RESET,
        ST_BURST_START,
        ST_BURST
    } state_t;

    state_t     state;
    state_t     state_nxt;
    logic       load;
    logic       extend;
    word_addr_t start_addr;
    word_addr_t next_addr;
    burst_len_t len;

    always_ff @(posedge clk) begin
        if (srst) begin
            state <= ST_RESET;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        load      = 1'b0;
        extend    = 1'b0;
        ctxt_push = 1'b0;
        case (state)
            // Idle, first cycle out of reset included
            ST_RESET, ST_BURST_START: begin
                load = 1'b1;
                if (accept) begin
                    state_nxt = ST_BURST;
                end
            end
            ST_BURST: begin
                if (accept) begin
                    if (addr == next_addr && len < burst_len_t'(MAX_BURST_LEN - 1)) begin
                        extend = 1'b1;
                    end else begin
                        // Close this burst, open the next with this request
                        ctxt_push = 1'b1;
                        load      = 1'b1;
                    end
                end else begin
                    // Gap in the request stream
                    ctxt_push = 1'b1;
                    state_nxt = ST_BURST_START;
                end
            end
            default: begin
                state_nxt = ST_RESET;
            end
        endcase
    end

    // Burst tracking
    always_ff @(posedge clk) begin
        if (load) begin
            start_addr <= addr;
            next_addr  <= addr + 1'b1;
            len        <= '0;
        end else if (extend) begin
            next_addr <= next_addr + 1'b1;
            len       <= len + 1'b1;
        end
    end

    assign ctxt = '{addr: start_addr, len: len};

endmodule : burst_coalescer

/* hdl/sync_fifo.sv */
/*
 * Synchronous show-ahead FIFO
 * Circular buffer with a type parameter for the payload.
 */
`timescale 1ns/1ns

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 16
) (
    input  logic clk,
    input  logic srst,

    input  logic wr,
    input  T     wr_data,
    output logic wr_rdy,

    input  logic rd,
    output logic rd_vld,
    output T     rd_data
);
    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    T                   mem [DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;
    logic               do_wr;
    logic               do_rd;

    // Pointer advance with wrap at DEPTH
    function automatic logic [PTR_WID-1:0] ptr_inc(input logic [PTR_WID-1:0] ptr);
        if (ptr == PTR_WID'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign wr_rdy = (count < CNT_WID'(DEPTH));
    assign rd_vld = (count != '0);

    // Writes while full and reads while empty are dropped
    assign do_wr = wr && wr_rdy;
    assign do_rd = rd && rd_vld;

    // Head entry shown without a read strobe
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : sync_fifo

/* hdl/mem_axi3_pkg.sv */
/*
 * Memory to AXI3 bridge definitions
 * Widths, burst limits, window base and the packed payload types
 * shared by the write and read paths.
 */
package mem_axi3_pkg;

    // ----------------------------------------
    // Widths and limits
    // ----------------------------------------
    localparam int DATA_BYTES    = 8;
    localparam int DATA_WID      = DATA_BYTES * 8;
    localparam int BYTE_SEL_WID  = $clog2(DATA_BYTES);
    localparam int WORD_ADDR_WID = 16;
    localparam int AXI_ADDR_WID  = 32;

    // Base of the mapped window, power of two
    localparam logic [AXI_ADDR_WID-1:0] BASE_ADDR = 32'h4000_0000;

    localparam int MAX_BURST_LEN   = 16;
    localparam int BURST_LEN_WID   = $clog2(MAX_BURST_LEN);
    localparam int DATA_FIFO_DEPTH = MAX_BURST_LEN;
    localparam int CTXT_FIFO_DEPTH = 2 * MAX_BURST_LEN;

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef logic [DATA_WID-1:0]      word_t;
    typedef logic [WORD_ADDR_WID-1:0] word_addr_t;
    typedef logic [AXI_ADDR_WID-1:0]  axi_addr_t;
    typedef logic [BURST_LEN_WID-1:0] burst_len_t;

    // Memory side write request
    typedef struct packed {
        word_addr_t addr;
        word_t      data;
    } mem_wr_req_t;

    // Start word address and beats minus one
    typedef struct packed {
        word_addr_t addr;
        burst_len_t len;
    } burst_ctxt_t;

    // AW and AR payload
    typedef struct packed {
        axi_addr_t  addr;
        burst_len_t len;
    } axi3_ax_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } axi3_w_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } axi3_r_t;

    // Word address to AXI byte address inside the window
    function automatic axi_addr_t word_to_axi_addr(input word_addr_t word_addr);
        axi_addr_t byte_offs;
        byte_offs = axi_addr_t'(word_addr) << BYTE_SEL_WID;
        return BASE_ADDR + byte_offs;
    endfunction

endpackage : mem_axi3_pkg
